// File: src/alu_params.svh
/*
 * ALU datapath parameters
 * Timer tap position and register file depth
 */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Bit of the timer register whose toggle gives a timer tick
// Valid from 14 to 31
`define ALU_TAP_BIT 16

// Register file depth
// Index type in alu_pkg is sized for this
`define ALU_NREGS 4

`endif

// File: src/alu_pkg.sv
/*
 * ALU datapath types
 * Operation encoding and the two views of the command word
 */
package alu_pkg;

    // Top bit picks the B column, low two bits pick the A column
    typedef enum logic [2:0] {
        near_xor = 3'b000, // D ^ ~Q
        pass_d   = 3'b001,
        near_and = 3'b010, // D & ~Q
        inv_q    = 3'b011,
        add      = 3'b100, // D + Q + cin
        shl_q    = 3'b101,
        near_ior = 3'b110, // ~D | Q
        pass_q   = 3'b111  // Q + cin
    } alu_op_e;

    typedef logic [1:0] reg_idx_t;

    // Register command, kind 0
    typedef struct packed {
        logic     kind;
        alu_op_e  op;
        logic     cin;
        reg_idx_t dst;
        reg_idx_t src_d;
        reg_idx_t src_adr;
        reg_idx_t src_qq;
        logic [2:0] spare;
    } alu_cmd_reg_t;

    // Immediate load, kind 1
    typedef struct packed {
        logic       kind;
        reg_idx_t   dst;
        logic       clr_timer;
        logic       clr_ofl;
        logic [10:0] spare;
    } alu_cmd_imm_t;

    typedef union packed {
        alu_cmd_reg_t cmd_reg;
        alu_cmd_imm_t cmd_imm;
    } alu_cmd_u;

endpackage

// File: src/alu_ctrl_if.sv
/*
 * Decoded ALU control
 * Carries one command from the decoder to register file, ALU and IRQ unit
 */
`timescale 1ns/1ns

interface alu_ctrl_if
    import alu_pkg::*;
();

    logic        valid;     // One cycle per command
    logic        is_imm;    // Immediate load form
    alu_op_e     op;
    logic        cin;
    reg_idx_t    dst;
    reg_idx_t    src_d;
    reg_idx_t    src_adr;
    reg_idx_t    src_qq;
    logic [31:0] imm_data;
    logic        clr_timer; // Only set by immediate commands
    logic        clr_ofl;

    modport decoder (output valid, is_imm, op, cin, dst, src_d, src_adr, src_qq,
                     imm_data, clr_timer, clr_ofl);

    modport datapath (input valid, is_imm, op, cin, dst, src_d, src_adr, src_qq,
                      imm_data, clr_timer, clr_ofl);

    modport irq (input valid, dst, clr_timer, clr_ofl);

endinterface

// File: src/m_alu.sv
/*
 * Two column ALU
 * A column mixes D and ADR, B column combines A with QQ
 * Also flags timer tap toggle and counter overflow on special writes
 */
`timescale 1ns/1ns
`include "alu_params.svh"

module m_alu
    import alu_pkg::*;
(
    alu_ctrl_if.datapath ctrl,
    input  logic [31:0]  d,         // First operand
    input  logic [31:0]  adr,       // Second operand of A column
    input  logic [31:0]  qq,        // Second operand of B column
    output logic [31:0]  b,         // ALU result
    output logic         carry_out,
    output logic         tap_out,   // Timer tick
    output logic         ofl_out    // Retired counter wrap
);

    logic [2:0]  op_bits;
    logic [31:0] a_col;
    logic [32:0] sum;
    logic        reg_cmd;
    logic        wr_timer;
    logic        wr_count;

    assign op_bits = ctrl.op;

    // A column
    always_comb begin
        case (op_bits[1:0])
            2'b00:   a_col = d;
            2'b01:   a_col = ~(d ^ adr);
            2'b10:   a_col = ~d & ~adr;
            default: a_col = 32'h0000_0000; // Q only ops
        endcase
    end

    // Full 33 bit add so the carry falls out of the top
    assign sum = {1'b0, a_col} + {1'b0, qq} + {32'h0000_0000, ctrl.cin};

    // B column
    assign b = op_bits[2] ? sum[31:0] : ~(a_col ^ qq);

    // No carry from the logic half
    assign carry_out = op_bits[2] & sum[32];

    // Special register writes
    assign reg_cmd  = ctrl.valid & ~ctrl.is_imm;
    assign wr_timer = reg_cmd & (ctrl.dst == 2'd3);
    assign wr_count = reg_cmd & (ctrl.dst == 2'd2);

    // Tap bit of old value against new value
    assign tap_out = wr_timer & (a_col[`ALU_TAP_BIT] ^ b[`ALU_TAP_BIT]);

    assign ofl_out = wr_count & carry_out; // Counter wrapped past bit 31

endmodule

// File: src/uop_decode.sv
/*
 * Command decoder
 * Registers the strobe and decodes either command form into ALU control
 */
`timescale 1ns/1ns

module uop_decode
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cmd_valid,  // Single cycle strobe
    input  alu_cmd_u    cmd_word,
    input  logic [31:0] cmd_data,   // Immediate payload
    alu_ctrl_if.decoder ctrl
);

    logic     nxt_is_imm;
    alu_op_e  nxt_op;
    logic     nxt_cin;
    reg_idx_t nxt_dst;
    reg_idx_t nxt_src_d;
    reg_idx_t nxt_src_adr;
    reg_idx_t nxt_src_qq;
    logic     nxt_clr_timer;
    logic     nxt_clr_ofl;

    // Pick the union view by the kind bit
    always_comb begin
        nxt_is_imm = cmd_word.cmd_imm.kind;
        if (nxt_is_imm) begin
            // Immediate load, ALU sources parked at zero
            nxt_op        = near_xor;
            nxt_cin       = 1'b0;
            nxt_dst       = cmd_word.cmd_imm.dst;
            nxt_src_d     = 2'd0;
            nxt_src_adr   = 2'd0;
            nxt_src_qq    = 2'd0;
            nxt_clr_timer = cmd_word.cmd_imm.clr_timer;
            nxt_clr_ofl   = cmd_word.cmd_imm.clr_ofl;
        end else begin
            nxt_op        = cmd_word.cmd_reg.op;
            nxt_cin       = cmd_word.cmd_reg.cin;
            nxt_dst       = cmd_word.cmd_reg.dst;
            nxt_src_d     = cmd_word.cmd_reg.src_d;
            nxt_src_adr   = cmd_word.cmd_reg.src_adr;
            nxt_src_qq    = cmd_word.cmd_reg.src_qq;
            nxt_clr_timer = 1'b0; // Clears only from immediates
            nxt_clr_ofl   = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl.valid     <= 1'b0;
            ctrl.is_imm    <= 1'b0;
            ctrl.op        <= near_xor;
            ctrl.cin       <= 1'b0;
            ctrl.dst       <= 2'd0;
            ctrl.src_d     <= 2'd0;
            ctrl.src_adr   <= 2'd0;
            ctrl.src_qq    <= 2'd0;
            ctrl.clr_timer <= 1'b0;
            ctrl.clr_ofl   <= 1'b0;
        end else begin
            ctrl.valid <= cmd_valid;
            if (cmd_valid) begin // Hold fields between commands
                ctrl.is_imm    <= nxt_is_imm;
                ctrl.op        <= nxt_op;
                ctrl.cin       <= nxt_cin;
                ctrl.dst       <= nxt_dst;
                ctrl.src_d     <= nxt_src_d;
                ctrl.src_adr   <= nxt_src_adr;
                ctrl.src_qq    <= nxt_src_qq;
                ctrl.clr_timer <= nxt_clr_timer;
                ctrl.clr_ofl   <= nxt_clr_ofl;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (cmd_valid)
            ctrl.imm_data <= cmd_data;
    end

endmodule

// File: src/reg_file.sv
/*
 * Register file
 * Four words, three combinational reads, one write per command
 * Register 2 is the retired counter and register 3 the timer
 */
`timescale 1ns/1ns
`include "alu_params.svh"

module reg_file (
    input  logic         clk,
    input  logic         arst_n,
    alu_ctrl_if.datapath ctrl,
    input  logic [31:0]  wdata_alu,    // ALU result
    input  logic         alu_carry,
    output logic [31:0]  rd_d,
    output logic [31:0]  rd_adr,
    output logic [31:0]  rd_qq,
    output logic [31:0]  result,       // Value last written
    output logic         result_carry,
    output logic         result_valid
);

    logic [31:0] regs [`ALU_NREGS];
    logic [31:0] wdata;

    // Read ports
    assign rd_d   = regs[ctrl.src_d];
    assign rd_adr = regs[ctrl.src_adr];
    assign rd_qq  = regs[ctrl.src_qq];

    assign wdata = ctrl.is_imm ? ctrl.imm_data : wdata_alu;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ALU_NREGS; i++)
                regs[i] <= 32'h0000_0000;
        end else if (ctrl.valid) begin
            regs[ctrl.dst] <= wdata;
        end
    end

    // Result stage, one cycle after the write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result       <= 32'h0000_0000;
            result_carry <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= ctrl.valid;
            if (ctrl.valid) begin
                result       <= wdata;
                result_carry <= alu_carry & ~ctrl.is_imm; // No carry on loads
            end
        end
    end

endmodule

// File: src/timer_irq.sv
/*
 * Counter interrupt flags
 * Sticky timer tick and counter overflow, cleared by immediate commands
 */
`timescale 1ns/1ns

module timer_irq (
    input  logic    clk,
    input  logic    arst_n,
    alu_ctrl_if.irq ctrl,
    input  logic    tap_pulse,  // From ALU tap detect
    input  logic    ofl_pulse,  // From ALU carry on register 2
    output logic    irq_timer,
    output logic    irq_ofl
);

    logic clr_timer;
    logic clr_ofl;

    // Clear bits are zero for register commands
    assign clr_timer = ctrl.valid & ctrl.clr_timer;
    assign clr_ofl   = ctrl.valid & ctrl.clr_ofl;

    // Set has priority over clear
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_timer <= 1'b0;
            irq_ofl   <= 1'b0;
        end else begin
            if (tap_pulse)
                irq_timer <= 1'b1;
            else if (clr_timer)
                irq_timer <= 1'b0;

            if (ofl_pulse)
                irq_ofl <= 1'b1;
            else if (clr_ofl)
                irq_ofl <= 1'b0;
        end
    end

endmodule

// File: src/alu_datapath_top.sv
/*
 * ALU datapath slice
 * Command decode, register file, ALU and counter interrupts
 * Two cycles from command strobe to result strobe
 */
`timescale 1ns/1ns

module alu_datapath_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cmd_valid,
    input  logic [15:0] cmd_word,
    input  logic [31:0] cmd_data,
    output logic        result_valid,
    output logic [31:0] result,
    output logic        result_carry,
    output logic        irq_timer,
    output logic        irq_ofl
);

    logic [31:0] rd_d;
    logic [31:0] rd_adr;
    logic [31:0] rd_qq;
    logic [31:0] alu_b;
    logic        alu_carry;
    logic        alu_tap;
    logic        alu_ofl;

    alu_ctrl_if ctrl_if ();

    uop_decode u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_word  (cmd_word),  // Raw word into the union
        .cmd_data  (cmd_data),
        .ctrl      (ctrl_if.decoder)
    );

    reg_file u_regs (
        .clk          (clk),
        .arst_n       (arst_n),
        .ctrl         (ctrl_if.datapath),
        .wdata_alu    (alu_b),
        .alu_carry    (alu_carry),
        .rd_d         (rd_d),
        .rd_adr       (rd_adr),
        .rd_qq        (rd_qq),
        .result       (result),
        .result_carry (result_carry),
        .result_valid (result_valid)
    );

    m_alu u_alu (
        .ctrl      (ctrl_if.datapath),
        .d         (rd_d),
        .adr       (rd_adr),
        .qq        (rd_qq),
        .b         (alu_b),
        .carry_out (alu_carry),
        .tap_out   (alu_tap),
        .ofl_out   (alu_ofl)
    );

    timer_irq u_irq (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl_if.irq),
        .tap_pulse (alu_tap),
        .ofl_pulse (alu_ofl),
        .irq_timer (irq_timer),
        .irq_ofl   (irq_ofl)
    );

endmodule

// File: bench/alu_datapath_properties.sv
/*
 * ALU datapath checks
 * Result strobe latency, sticky flag behaviour, known outputs
 */
`timescale 1ns/1ns

module alu_datapath_properties (
    input logic        clk,
    input logic        arst_n,
    input logic        cmd_valid,
    input logic [15:0] cmd_word,
    input logic        result_valid,
    input logic [31:0] result,
    input logic        result_carry,
    input logic        irq_timer,
    input logic        irq_ofl
);

    // Strobe to result is exactly two cycles
    assert property (@(posedge clk) disable iff (!arst_n)
        result_valid == $past(cmd_valid, 2))
        else $error("result_valid out of step with cmd_valid");

    // Immediate with clr_timer (bit 12) two cycles back
    assert property (@(posedge clk) disable iff (!arst_n)
        $fell(irq_timer) |-> $past(cmd_valid && cmd_word[15] && cmd_word[12], 2))
        else $error("irq_timer dropped without a clear");

    // Same for clr_ofl (bit 11)
    assert property (@(posedge clk) disable iff (!arst_n)
        $fell(irq_ofl) |-> $past(cmd_valid && cmd_word[15] && cmd_word[11], 2))
        else $error("irq_ofl dropped without a clear");

    assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({result_valid, result, result_carry, irq_timer, irq_ofl}))
        else $error("unknown value on a DUT output");

endmodule

bind alu_datapath_top alu_datapath_properties props_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_valid    (cmd_valid),
    .cmd_word     (cmd_word),
    .result_valid (result_valid),
    .result       (result),
    .result_carry (result_carry),
    .irq_timer    (irq_timer),
    .irq_ofl      (irq_ofl)
);

// File: bench/tb_alu_datapath.sv
/*
 * Testbench for the ALU datapath slice
 * Drives immediate and register commands, models the two column ALU,
 * the register file and the sticky flags, and checks every result strobe
 */
`timescale 1ns/1ns
`include "alu_params.svh"

module tb_alu_datapath;

    // Command counts per test, used for the run limit
    localparam int T1_CMDS = 12;
    localparam int T2_CMDS = 48;
    localparam int T3_CMDS = 18;
    localparam int T4_CMDS = 9;
    localparam int T5_CMDS = 6;
    localparam int TOTAL_CMDS = T1_CMDS + T2_CMDS + T3_CMDS + T4_CMDS + T5_CMDS;
    localparam int MAX_CYCLES = TOTAL_CMDS * 4 + 200;

    typedef struct packed {
        logic [31:0] result;
        logic        carry;
        logic        irq_t;
        logic        irq_o;
        logic [31:0] cyc;   // Cycle the strobe is due
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        cmd_valid;
    logic [15:0] cmd_word;
    logic [31:0] cmd_data;
    logic        result_valid;
    logic [31:0] result;
    logic        result_carry;
    logic        irq_timer;
    logic        irq_ofl;

    int          seed;
    int          cycle_cnt;
    int          err_cnt;
    int          check_cnt;
    int          test_errs;
    int          test_checks;
    logic [31:0] model_regs [`ALU_NREGS]; // Mirror of the register file
    logic        model_irq_t;
    logic        model_irq_o;
    expect_t     exp_q[$];
    expect_t     cur_exp;

    alu_datapath_top alu_datapath_top_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd_valid    (cmd_valid),
        .cmd_word     (cmd_word),
        .cmd_data     (cmd_data),
        .result_valid (result_valid),
        .result       (result),
        .result_carry (result_carry),
        .irq_timer    (irq_timer),
        .irq_ofl      (irq_ofl)
    );

    always #20 clk = ~clk; // 40 ns period

    // Two column rule: A from D and ADR, B from A and QQ
    function automatic void alu_ref(input logic [2:0] op, input logic cin,
                                    input logic [31:0] d, input logic [31:0] adr,
                                    input logic [31:0] qq, output logic [31:0] a,
                                    output logic [31:0] b, output logic carry);
        logic [32:0] sum;
        case (op[1:0])
            2'b00:   a = d;
            2'b01:   a = ~(d ^ adr);
            2'b10:   a = ~(d | adr);
            default: a = 32'h0000_0000;
        endcase
        sum = {1'b0, a} + {1'b0, qq} + 33'(cin);
        if (op[2]) begin
            b     = sum[31:0];
            carry = sum[32];
        end else begin
            b     = ~(a ^ qq);
            carry = 1'b0; // Logic half has no carry
        end
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        check_cnt++;
        test_checks++;
        if (got !== want) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, want);
            err_cnt++;
            test_errs++;
        end
    endtask

    // Strobe for one cycle, called on a falling edge
    task automatic send_cmd(input logic [15:0] word, input logic [31:0] data);
        cmd_valid = 1'b1;
        cmd_word  = word;
        cmd_data  = data;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic issue_reg(input logic [2:0] op, input logic cin, input logic [1:0] dst,
                             input logic [1:0] sd, input logic [1:0] sa, input logic [1:0] sq);
        logic [31:0] a;
        logic [31:0] b;
        logic        carry;
        expect_t     e;
        alu_ref(op, cin, model_regs[sd], model_regs[sa], model_regs[sq], a, b, carry);
        if (dst == 2'd3 && a[`ALU_TAP_BIT] != b[`ALU_TAP_BIT])
            model_irq_t = 1'b1; // Timer tick
        if (dst == 2'd2 && carry)
            model_irq_o = 1'b1; // Counter wrap
        model_regs[dst] = b;
        e.result = b;
        e.carry  = carry;
        e.irq_t  = model_irq_t;
        e.irq_o  = model_irq_o;
        e.cyc    = cycle_cnt + 2;
        exp_q.push_back(e);
        send_cmd({1'b0, op, cin, dst, sd, sa, sq, 3'b000}, $random(seed));
    endtask

    task automatic issue_imm(input logic [1:0] dst, input logic clr_t, input logic clr_o,
                             input logic [31:0] data);
        expect_t e;
        if (clr_t)
            model_irq_t = 1'b0;
        if (clr_o)
            model_irq_o = 1'b0;
        model_regs[dst] = data;
        e.result = data;
        e.carry  = 1'b0;
        e.irq_t  = model_irq_t;
        e.irq_o  = model_irq_o;
        e.cyc    = cycle_cnt + 2;
        exp_q.push_back(e);
        send_cmd({1'b1, dst, clr_t, clr_o, 11'd0}, data);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic report_test(input string name);
        wait_drain();
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, results stopped arriving", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    // Compare mid cycle, outputs settled
    always @(negedge clk) begin
        if (arst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("result_valid at %0t with no command outstanding", $time);
                err_cnt++;
                test_errs++;
            end else begin
                cur_exp = exp_q.pop_front();
                check_val("result", result, cur_exp.result);
                check_val("result_carry", 32'(result_carry), 32'(cur_exp.carry));
                check_val("irq_timer", 32'(irq_timer), 32'(cur_exp.irq_t));
                check_val("irq_ofl", 32'(irq_ofl), 32'(cur_exp.irq_o));
                check_val("result_valid cycle", cycle_cnt, cur_exp.cyc);
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [1:0]  cur;
        logic [1:0]  prv;
        clk         = 1'b0;
        arst_n      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_word    = 16'h0000;
        cmd_data    = 32'h0000_0000;
        seed        = 32'h056a_5002;
        cycle_cnt   = 0;
        err_cnt     = 0;
        check_cnt   = 0;
        test_errs   = 0;
        test_checks = 0;
        model_irq_t = 1'b0;
        model_irq_o = 1'b0;
        for (int i = 0; i < `ALU_NREGS; i++)
            model_regs[i] = 32'h0000_0000;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Loads, then read back with all sources on one register
        for (int k = 0; k < 4; k++)
            issue_imm(2'(k), 1'b0, 1'b0, $random(seed));
        for (int k = 0; k < 4; k++) begin
            issue_reg(3'b001, 1'b0, 2'(k), 2'(k), 2'(k), 2'(k)); // pass_d
            issue_reg(3'b111, 1'b0, 2'(k), 2'(k), 2'(k), 2'(k)); // pass_q
        end
        report_test("imm_readback");

        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++)
                issue_imm(2'(k), 1'b0, 1'b0, $random(seed));
            for (int k = 0; k < 8; k++) begin
                rnd = $random(seed);
                issue_reg(3'(k), rnd[0], rnd[2:1], rnd[4:3], rnd[6:5], rnd[8:7]);
            end
        end
        report_test("all_ops");

        // Chain alternates r0 and r1, each reading the other
        issue_imm(2'd0, 1'b0, 1'b0, $random(seed));
        issue_imm(2'd1, 1'b0, 1'b0, $random(seed));
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            cur = i[0] ? 2'd1 : 2'd0;
            prv = i[0] ? 2'd0 : 2'd1;
            issue_reg(rnd[2:0], rnd[3], cur, prv, prv, rnd[4] ? cur : prv);
        end
        report_test("back_to_back");

        // Timer counts across the tap boundary on the third add
        issue_imm(2'd0, 1'b1, 1'b1, 32'h0000_0000);
        issue_imm(2'd3, 1'b1, 1'b0, (32'd1 << `ALU_TAP_BIT) - 32'd3);
        for (int i = 0; i < 6; i++)
            issue_reg(3'b100, 1'b1, 2'd3, 2'd3, 2'd0, 2'd0);
        wait_drain();
        check_val("irq_timer", 32'(irq_timer), 32'd1);
        issue_imm(2'd1, 1'b1, 1'b0, $random(seed));
        wait_drain();
        check_val("irq_timer", 32'(irq_timer), 32'd0);
        report_test("timer_tap");

        issue_imm(2'd0, 1'b0, 1'b0, 32'h0000_0000);
        issue_imm(2'd2, 1'b0, 1'b1, 32'hffff_ffff);
        issue_reg(3'b100, 1'b1, 2'd2, 2'd2, 2'd0, 2'd0); // Wraps to zero
        wait_drain();
        check_val("irq_ofl", 32'(irq_ofl), 32'd1);
        issue_imm(2'd1, 1'b0, 1'b1, $random(seed));
        issue_reg(3'b100, 1'b1, 2'd2, 2'd2, 2'd0, 2'd0);
        issue_reg(3'b100, 1'b1, 2'd2, 2'd2, 2'd0, 2'd0);
        wait_drain();
        check_val("irq_ofl", 32'(irq_ofl), 32'd0);
        report_test("counter_overflow");

        $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/alu_pkg.sv
src/alu_ctrl_if.sv
src/m_alu.sv
src/uop_decode.sv
src/reg_file.sv
src/timer_irq.sv
src/alu_datapath_top.sv
bench/alu_datapath_properties.sv
bench/tb_alu_datapath.sv

// File: Makefile
TOP := tb_alu_datapath

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

obj_dir/V$(TOP): all.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
